// File: rtl/cdcFifo_defs.svh
/*
  Build-time configuration of the clock-domain-crossing FIFO
  - Entry count and word width
  - RAM address and pointer widths
  - Synchronizer chain length
*/

`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// Number of entries, which must be a power of two so pointers wrap cleanly
`define FIFO_DEPTH 8

// Data bits carried by each entry
`define FIFO_WIDTH 16

// Address bits needed to index FIFO_DEPTH entries
`define FIFO_ADDR_WIDTH 3

// Address bits plus one wrap bit, which tells full apart from empty
// The same width holds counts from 0 up to FIFO_DEPTH
`define FIFO_PTR_WIDTH 4

// Flops in each gray pointer synchronizer chain
`define CDC_SYNC_STAGES 2

`endif

// File: rtl/cdcFifoPkg.sv
/*
  Shared types and helpers of the CDC FIFO
  - Word, address and pointer types
  - Pop output register state enum
  - Binary/gray pointer conversion functions
*/

`default_nettype none

`include "cdcFifo_defs.svh"

package cdcFifoPkg;

  typedef logic [`FIFO_WIDTH-1:0] dataT;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addrT;
  // Used for binary pointers, gray pointers and item counts alike
  typedef logic [`FIFO_PTR_WIDTH-1:0] ptrT;

  // Pop output register states for empty, waiting on the RAM and holding a word
  typedef enum logic [1:0] {popIdle, popFetch, popHold} popStateT;

  function automatic ptrT bin2gray(input ptrT bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all gray bits at or above it
  function automatic ptrT gray2bin(input ptrT gray);
    ptrT bin;
    bin[`FIFO_PTR_WIDTH-1] = gray[`FIFO_PTR_WIDTH-1];
    for (int i = `FIFO_PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: rtl/grayPtrSync.sv
/*
  Gray pointer synchronizer
  - Flop chain of CDC_SYNC_STAGES stages on the receiving clock
  - Gray to binary conversion of the last stage
  - Check that the synchronized pointer moves one gray step at a time
*/

`default_nettype none

`include "cdcFifo_defs.svh"

module grayPtrSync (
  input  wire logic            clk,
  input  wire logic            rstN,
  // Gray pointer launched from a register in the other clock domain
  input  wire cdcFifoPkg::ptrT grayIn,
  // Synchronized pointer already converted back to binary
  output cdcFifoPkg::ptrT      binOut
);

  import cdcFifoPkg::*;

  // Stage 0 is the only flop that samples the asynchronous input
  ptrT syncQ [`CDC_SYNC_STAGES];

  // --------------------------------------------------------------------------
  // Synchronizer chain
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
        syncQ[i] <= '0;
      end
    end else begin
      syncQ[0] <= grayIn;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        syncQ[i] <= syncQ[i-1];
      end
    end
  end

  // Only the settled last stage is converted, so no binary value ever
  // reflects a half-captured gray code
  assign binOut = gray2bin(syncQ[`CDC_SYNC_STAGES-1]);

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // The source register moves one gray step per update, so the receiving
  // side may lag but never sees a multi-bit jump between its samples
  syncOneStep: assert property (@(posedge clk) disable iff (!rstN)
    $countones(syncQ[`CDC_SYNC_STAGES-1] ^ $past(syncQ[`CDC_SYNC_STAGES-1])) <= 1);

endmodule

`default_nettype wire

// File: rtl/cdcPushCtrl.sv
/*
  Push-side controller of the CDC FIFO
  - Binary write pointer and its gray copy for the pop domain
  - Occupancy from the synchronized read pointer
  - Full flag, free slot count and push ready
  - RAM write strobe, address and data for each accepted push
*/

`default_nettype none

`include "cdcFifo_defs.svh"

module cdcPushCtrl (
  input  wire logic             pushClk,
  input  wire logic             rstN,
  // Push handshake
  input  wire logic             pushValid,
  input  wire cdcFifoPkg::dataT pushData,
  output logic                  pushReady,
  // Push-side status
  output logic                  pushFull,
  output cdcFifoPkg::ptrT       pushSlots,
  // Write port of the flop RAM
  output logic                  ramWrEn,
  output cdcFifoPkg::addrT      ramWrAddr,
  output cdcFifoPkg::dataT      ramWrData,
  // Pointers crossing between the domains
  input  wire cdcFifoPkg::ptrT  rdPtrGray,
  output cdcFifoPkg::ptrT       wrPtrGray
);

  import cdcFifoPkg::*;

  ptrT  wrPtr;
  ptrT  rdPtrSync;
  ptrT  occupancy;
  logic pushAccept;

  // Bring the pop side's gray read pointer into this domain
  grayPtrSync rdSync0 (
    .clk    (pushClk),
    .rstN   (rstN),
    .grayIn (rdPtrGray),
    .binOut (rdPtrSync)
  );

  // --------------------------------------------------------------------------
  // Occupancy and flow control
  // --------------------------------------------------------------------------

  // The synchronized read pointer lags the real one, so this occupancy is
  // pessimistic and the FIFO can never be overfilled
  assign occupancy = wrPtr - rdPtrSync;

  assign pushFull  = (occupancy == ptrT'(`FIFO_DEPTH));
  assign pushSlots = ptrT'(`FIFO_DEPTH) - occupancy;
  assign pushReady = !pushFull;

  assign pushAccept = pushValid && pushReady;

  // --------------------------------------------------------------------------
  // RAM write
  // --------------------------------------------------------------------------

  // The word goes into the RAM at the same edge that advances the pointer
  assign ramWrEn   = pushAccept;
  assign ramWrAddr = wrPtr[`FIFO_ADDR_WIDTH-1:0];
  assign ramWrData = pushData;

  // --------------------------------------------------------------------------
  // Write pointer
  // --------------------------------------------------------------------------

  // The gray copy is a register of its own, so the pop domain only ever
  // samples a flop output that changes one bit at a time
  always_ff @(posedge pushClk) begin
    if (!rstN) begin
      wrPtr     <= '0;
      wrPtrGray <= '0;
    end else if (pushAccept) begin
      wrPtr     <= wrPtr + ptrT'(1);
      wrPtrGray <= bin2gray(wrPtr + ptrT'(1));
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Once full, the next write has to wait for a pop seen through the synchronizer
  noWriteWhileFull: assert property (@(posedge pushClk) disable iff (!rstN)
    pushFull |=> !ramWrEn || $changed(rdPtrSync));

  // The pop side never frees more entries than were written
  occupancyBound: assert property (@(posedge pushClk) disable iff (!rstN)
    occupancy <= ptrT'(`FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rtl/cdcPopCtrl.sv
/*
  Pop-side controller of the CDC FIFO
  - Read pointer for RAM fetches and popped pointer for the push domain
  - Item count and empty flag from the synchronized write pointer
  - Output register FSM: idle, fetch outstanding, word held
  - RAM read issue and the pop data holding register
*/

`default_nettype none

`include "cdcFifo_defs.svh"

module cdcPopCtrl (
  input  wire logic             popClk,
  input  wire logic             rstN,
  // Pop handshake
  input  wire logic             popReady,
  output logic                  popValid,
  output cdcFifoPkg::dataT      popData,
  // Pop-side status
  output logic                  popEmpty,
  output cdcFifoPkg::ptrT       popItems,
  // Read port of the flop RAM
  output logic                  ramRdEn,
  output cdcFifoPkg::addrT      ramRdAddr,
  input  wire cdcFifoPkg::dataT ramRdData,
  // Pointers crossing between the domains
  input  wire cdcFifoPkg::ptrT  wrPtrGray,
  output cdcFifoPkg::ptrT       rdPtrGray
);

  import cdcFifoPkg::*;

  popStateT popState;
  popStateT popStateNext;
  // Next entry to fetch from the RAM
  ptrT      rdPtr;
  // Next entry to leave through the pop handshake
  ptrT      poppedPtr;
  ptrT      wrPtrSync;
  ptrT      unreadCnt;
  logic     popTake;
  logic     readIssue;

  // Bring the push side's gray write pointer into this domain
  grayPtrSync wrSync0 (
    .clk    (popClk),
    .rstN   (rstN),
    .grayIn (wrPtrGray),
    .binOut (wrPtrSync)
  );

  // --------------------------------------------------------------------------
  // Counts and status
  // --------------------------------------------------------------------------

  // Entries visible here but not yet fetched from the RAM
  assign unreadCnt = wrPtrSync - rdPtr;

  // Everything visible and not yet popped including a word in fetch or held
  assign popItems = wrPtrSync - poppedPtr;
  assign popEmpty = (popItems == '0);

  assign popValid = (popState == popHold);
  assign popTake  = popValid && popReady;

  // --------------------------------------------------------------------------
  // Read issue
  // --------------------------------------------------------------------------

  // A fetch may start when the output register is empty, or in the same
  // cycle that its word is taken, so one word is held and one in flight
  assign readIssue = (unreadCnt != '0) && ((popState == popIdle) || popTake);

  assign ramRdEn   = readIssue;
  assign ramRdAddr = rdPtr[`FIFO_ADDR_WIDTH-1:0];

  // --------------------------------------------------------------------------
  // Output register FSM
  // --------------------------------------------------------------------------

  always_comb begin
    popStateNext = popState;
    case (popState)
      popIdle: begin
        if (readIssue) popStateNext = popFetch;
      end
      // The RAM output is valid now and is loaded at this edge
      popFetch: popStateNext = popHold;
      popHold: begin
        if (popTake) popStateNext = readIssue ? popFetch : popIdle;
      end
      default: popStateNext = popIdle;
    endcase
  end

  always_ff @(posedge popClk) begin
    if (!rstN) begin
      popState  <= popIdle;
      rdPtr     <= '0;
      poppedPtr <= '0;
      rdPtrGray <= '0;
    end else begin
      popState <= popStateNext;
      if (readIssue) rdPtr <= rdPtr + ptrT'(1);
      // The slot is freed only once its word has left, never at fetch time
      if (popTake) begin
        poppedPtr <= poppedPtr + ptrT'(1);
        rdPtrGray <= bin2gray(poppedPtr + ptrT'(1));
      end
    end
  end

  // Holding register for the popped word
  always_ff @(posedge popClk) begin
    if (popState == popFetch) popData <= ramRdData;
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // A stalled word stays put until the consumer takes it
  popDataHeld: assert property (@(posedge popClk) disable iff (!rstN)
    popValid && !popReady |=> popValid && $stable(popData));

  // At most one fetched word is waiting to be popped at any time
  oneInFlight: assert property (@(posedge popClk) disable iff (!rstN)
    (rdPtr - poppedPtr) <= ptrT'(1));

endmodule

`default_nettype wire

// File: rtl/cdcFlopRam.sv
/*
  Dual-clock flop RAM of the CDC FIFO
  - FIFO_DEPTH words, written on the push clock
  - Registered read port on the pop clock
  - Check on read address and returned data
*/

`default_nettype none

`include "cdcFifo_defs.svh"

module cdcFlopRam (
  // Write port in the push clock domain
  input  wire logic             pushClk,
  input  wire logic             ramWrEn,
  input  wire cdcFifoPkg::addrT ramWrAddr,
  input  wire cdcFifoPkg::dataT ramWrData,
  // Read port in the pop clock domain
  input  wire logic             popClk,
  input  wire logic             ramRdEn,
  input  wire cdcFifoPkg::addrT ramRdAddr,
  output cdcFifoPkg::dataT      ramRdData
);

  import cdcFifoPkg::*;

  // Storage array of FIFO_DEPTH words
  dataT mem [`FIFO_DEPTH];

  // --------------------------------------------------------------------------
  // Write port
  // --------------------------------------------------------------------------

  always_ff @(posedge pushClk) begin
    if (ramWrEn) mem[ramWrAddr] <= ramWrData;
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------

  // The cell being read was written at least a full synchronizer delay ago,
  // so the asynchronous path through the array is stable when sampled here
  always_ff @(posedge popClk) begin
    if (ramRdEn) ramRdData <= mem[ramRdAddr];
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // A read needs a known address and must return a word that was written
  // before its pointer crossed over from the push side
  readKnown: assert property (@(posedge popClk)
    ramRdEn |-> !$isunknown(ramRdAddr) ##1 !$isunknown(ramRdData));

endmodule

`default_nettype wire

// File: rtl/cdcFifoFlops.sv
/*
  Top level of the CDC FIFO with internal flop RAM
  - Push controller in the push clock domain
  - Pop controller in the pop clock domain
  - Dual-clock flop RAM between them
*/

`default_nettype none

module cdcFifoFlops (
  input  wire logic             pushClk,
  input  wire logic             popClk,
  // Sampled separately on each clock
  input  wire logic             rstN,
  // Push interface
  input  wire logic             pushValid,
  input  wire cdcFifoPkg::dataT pushData,
  output logic                  pushReady,
  output logic                  pushFull,
  output cdcFifoPkg::ptrT       pushSlots,
  // Pop interface
  input  wire logic             popReady,
  output logic                  popValid,
  output cdcFifoPkg::dataT      popData,
  output logic                  popEmpty,
  output cdcFifoPkg::ptrT       popItems
);

  import cdcFifoPkg::*;

  // RAM write port in the push domain
  logic ramWrEn;
  addrT ramWrAddr;
  dataT ramWrData;

  // RAM read port in the pop domain
  logic ramRdEn;
  addrT ramRdAddr;
  dataT ramRdData;

  // Gray pointers that each leave a register in their own domain
  ptrT  wrPtrGray;
  ptrT  rdPtrGray;

  cdcPushCtrl pushCtrl0 (
    .pushClk,
    .rstN,
    .pushValid,
    .pushData,
    .pushReady,
    .pushFull,
    .pushSlots,
    .ramWrEn,
    .ramWrAddr,
    .ramWrData,
    .rdPtrGray,
    .wrPtrGray
  );

  cdcPopCtrl popCtrl0 (
    .popClk,
    .rstN,
    .popReady,
    .popValid,
    .popData,
    .popEmpty,
    .popItems,
    .ramRdEn,
    .ramRdAddr,
    .ramRdData,
    .wrPtrGray,
    .rdPtrGray
  );

  cdcFlopRam ram0 (
    .pushClk,
    .ramWrEn,
    .ramWrAddr,
    .ramWrData,
    .popClk,
    .ramRdEn,
    .ramRdAddr,
    .ramRdData
  );

endmodule

`default_nettype wire

// File: tb/cdcFifoTb.sv
/*
  Testbench of the CDC FIFO with internal flop RAM
  - Push and pop clocks with offset edges, reset
  - Stimulus table of streaming rows applied in a loop
  - Reference queue of accepted words, data and status checks
  - Per-row report and closing summary
*/

`default_nettype none

`include "cdcFifo_defs.svh"

module cdcFifoTb;

  import cdcFifoPkg::*;

  localparam int ROWS = 6;
  localparam int SEED = 48927;
  localparam int WAIT_LIMIT = 5000;

  // One row gives the words to push, the push valid and pop ready chances in
  // percent and whether pops wait until every push of the row is done
  typedef struct packed {
    int   count;
    int   validPct;
    int   readyPct;
    logic blockPops;
  } rowT;

  // Row 0 is a single word, row 1 fills the FIFO and drains it with stalls
  localparam rowT STIM [ROWS] = '{
    '{1, 100, 100, 1'b0},
    '{`FIFO_DEPTH, 100, 50, 1'b1},
    '{40, 70, 60, 1'b0},
    '{40, 100, 30, 1'b0},
    '{40, 30, 100, 1'b0},
    '{60, 50, 50, 1'b0}
  };

  logic pushClk;
  logic popClk;
  logic rstN;
  logic pushValid;
  dataT pushData;
  logic pushReady;
  logic pushFull;
  ptrT  pushSlots;
  logic popReady;
  logic popValid;
  dataT popData;
  logic popEmpty;
  ptrT  popItems;

  // Words accepted on the push side and not yet popped in push order
  dataT refQ [$];
  int   errors;
  int   checks;
  int   rowPushes;
  int   rowPops;
  bit   timedOut;
  bit   pushDone;

  cdcFifoFlops dut0 (
    .pushClk, .popClk, .rstN,
    .pushValid, .pushData, .pushReady, .pushFull, .pushSlots,
    .popReady, .popValid, .popData, .popEmpty, .popItems
  );

  initial begin
    pushClk = 1'b0;
    forever #4 pushClk = ~pushClk;
  end

  // Offset by 3 so the two clocks never share an edge
  initial begin
    popClk = 1'b0;
    #3;
    forever #4 popClk = ~popClk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic noteTimeout(input string what);
    $display("Timed out while waiting for %s", what);
    errors++;
    timedOut = 1'b1;
  endtask

  function automatic bit coin(input int pct);
    return int'($urandom() % 100) < pct;
  endfunction

  // --------------------------------------------------------------------------
  // Push side
  // --------------------------------------------------------------------------

  task automatic pushRow(input rowT row);
    int accepted;
    int cycles;
    accepted = 0;
    cycles = 0;
    while (accepted < row.count && !timedOut) begin
      @(posedge pushClk);
      cycles++;
      checks++;
      assert (pushSlots <= ptrT'(`FIFO_DEPTH)) else begin
        $display("[ERROR] pushSlots = 0x%0h, above 0x%0h", pushSlots, `FIFO_DEPTH);
        errors++;
      end
      if (pushValid && pushReady) begin
        refQ.push_back(pushData);
        accepted++;
      end
      if (cycles > WAIT_LIMIT) begin
        noteTimeout("push acceptance");
      end else if (accepted == row.count) begin
        pushValid <= 1'b0;
      end else if (!(pushValid && !pushReady)) begin
        // A word that is offered but not yet taken keeps its value
        pushValid <= coin(row.validPct);
        pushData  <= dataT'($urandom());
      end
    end
    pushValid <= 1'b0;
    rowPushes = accepted;
    // A full FIFO with pops blocked must refuse one more word
    if (row.blockPops && !timedOut) begin
      pushValid <= 1'b1;
      pushData  <= dataT'($urandom());
      repeat (8) begin
        @(posedge pushClk);
        checkEq("pushReady", 32'(pushReady), 32'd0);
        checkEq("pushFull", 32'(pushFull), 32'd1);
        checkEq("pushSlots", 32'(pushSlots), 32'd0);
      end
      pushValid <= 1'b0;
    end
  endtask

  // Once the pops are seen through the synchronizer, all slots come back
  task automatic drainWaitPush();
    int cycles;
    cycles = 0;
    while (!(pushReady && pushSlots == ptrT'(`FIFO_DEPTH)) && !timedOut) begin
      @(posedge pushClk);
      cycles++;
      if (cycles > WAIT_LIMIT) noteTimeout("pushReady and all slots after the drain");
    end
  endtask

  // --------------------------------------------------------------------------
  // Pop side
  // --------------------------------------------------------------------------

  task automatic popRow(input rowT row);
    int   popped;
    int   cycles;
    bit   prevStall;
    dataT prevData;
    popped = 0;
    cycles = 0;
    prevStall = 1'b0;
    prevData = '0;
    if (row.blockPops) begin
      while (!(pushDone && popItems == ptrT'(row.count)) && !timedOut) begin
        @(posedge popClk);
        cycles++;
        if (cycles > WAIT_LIMIT) noteTimeout("popItems to reach the pushed count");
      end
    end
    cycles = 0;
    while (popped < row.count && !timedOut) begin
      @(posedge popClk);
      cycles++;
      if (popValid && popReady) begin
        if (refQ.size() == 0) begin
          $display("A pop completed while no pushed word was outstanding");
          errors++;
        end else begin
          checkEq("popData", 32'(popData), 32'(refQ[0]));
          void'(refQ.pop_front());
        end
        popped++;
      end else if (popValid) begin
        // Stalled word must be the oldest one and must not move
        if (refQ.size() > 0) checkEq("popData", 32'(popData), 32'(refQ[0]));
        if (prevStall) checkEq("popData while stalled", 32'(popData), 32'(prevData));
      end
      prevStall = popValid && !popReady;
      prevData = popData;
      if (cycles > WAIT_LIMIT) noteTimeout("pop completion");
      else popReady <= (popped < row.count) && coin(row.readyPct);
    end
    popReady <= 1'b0;
    rowPops = popped;
    cycles = 0;
    while (!popEmpty && !timedOut) begin
      @(posedge popClk);
      cycles++;
      if (cycles > WAIT_LIMIT) noteTimeout("popEmpty after the last pop");
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    rstN = 1'b0;
    pushValid = 1'b0;
    pushData = '0;
    popReady = 1'b0;
    errors = 0;
    checks = 0;
    timedOut = 1'b0;
    pushDone = 1'b0;
    void'($urandom(SEED));

    // Four push cycles cover at least three pop cycles as well
    repeat (4) @(posedge pushClk);
    rstN <= 1'b1;
    @(posedge pushClk);
    checkEq("pushReady", 32'(pushReady), 32'd1);
    checkEq("pushFull", 32'(pushFull), 32'd0);
    checkEq("pushSlots", 32'(pushSlots), 32'(`FIFO_DEPTH));
    checkEq("popValid", 32'(popValid), 32'd0);
    checkEq("popEmpty", 32'(popEmpty), 32'd1);
    checkEq("popItems", 32'(popItems), 32'd0);

    for (int r = 0; r < ROWS && !timedOut; r++) begin
      pushDone = 1'b0;
      fork
        begin
          pushRow(STIM[r]);
          pushDone = 1'b1;
          drainWaitPush();
        end
        popRow(STIM[r]);
      join
      $display("Row %0d: %0d pushed, %0d popped, %0d errors so far",
               r, rowPushes, rowPops, errors);
    end

    // With nothing left to deliver, an open consumer must see no stray word
    if (!timedOut) begin
      @(posedge popClk);
      popReady <= 1'b1;
      repeat (8) begin
        @(posedge popClk);
        checkEq("popValid", 32'(popValid), 32'd0);
      end
      popReady <= 1'b0;
    end

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/cdcFifoPkg.sv
rtl/grayPtrSync.sv
rtl/cdcPushCtrl.sv
rtl/cdcPopCtrl.sv
rtl/cdcFlopRam.sv
rtl/cdcFifoFlops.sv
tb/cdcFifoTb.sv

// File: run.sh
#!/bin/sh
# Builds the CDC FIFO testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f build.f --top-module cdcFifoTb -Mdir obj_dir > sim.log 2>&1 \
  && ./obj_dir/VcdcFifoTb >> sim.log 2>&1

grep -qx "Simulation PASSED" sim.log && echo "Run passed" || { cat sim.log; exit 1; }
